/* logic/mac_pkg.sv */
////////////////////////////////////////////////////////////
// mac lane widths, element format enum and element union
// product bundle interface between stage 0 and stage 1
////////////////////////////////////////////////////////////
`default_nettype none

package mac_pkg;

    localparam int W_ELEM    = 10;
    localparam int W_EXP     = 4;
    localparam int W_PEXP    = 5;   // sum of two fp8 exponents
    localparam int W_PMAG    = 16;  // int9 magnitude product
    localparam int W_PROD    = 17;
    localparam int SHIFT_CAP = 17;  // anything beyond leaves 0 or -1

    typedef enum logic {
        MODE_FP8  = 1'b0,
        MODE_INT9 = 1'b1
    } mac_mode_e;

    typedef struct packed {
        logic             is_zero;
        logic             sign;
        logic [W_EXP-1:0] exp;
        logic [3:0]       mant;     // no hidden bit
    } mac_fp8_s;

    typedef struct packed {
        logic       is_zero;
        logic       sign;
        logic [7:0] mag;
    } mac_int9_s;

    // one element word, viewed per mode
    typedef union packed {
        mac_fp8_s  fp8;
        mac_int9_s int9;
    } mac_elem_u;

endpackage

interface mac_prod_if #(parameter int N_LANES = 8);
    import mac_pkg::*;

    logic [N_LANES-1:0]              sign;
    logic [N_LANES-1:0][W_PEXP-1:0]  exp;
    logic [N_LANES-1:0][W_PMAG-1:0]  mag;
    logic [N_LANES-1:0]              keep;  // element valid and not zero
    mac_mode_e                       mode;

    modport src (output sign, exp, mag, keep, mode);
    modport dst (input  sign, exp, mag, keep, mode);
endinterface

`default_nettype wire

/* logic/mac_pipe_ctrl.sv */
////////////////////////////////////////////////////////////
// pipeline control: stage valid bits, stage load enables,
// ifm/wfm join and ofm handshake
////////////////////////////////////////////////////////////
`default_nettype none

module mac_pipe_ctrl #(
    parameter int N_STAGES = 4
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_ifm_valid,
    input  logic                i_wfm_valid,
    output logic                o_ifm_ready,
    output logic                o_wfm_ready,
    input  logic                i_ofm_ready,
    output logic                o_ofm_valid,
    output logic [N_STAGES-1:0] o_stage_en
);

    logic [N_STAGES-1:0] r_valid;
    logic [N_STAGES-1:0] stage_en;
    logic                take;

    // a stage loads when empty or when its contents move on
    always_comb begin
        stage_en[N_STAGES-1] = ~r_valid[N_STAGES-1] | i_ofm_ready;
        for (int s = N_STAGES - 2; s >= 0; s--) begin
            stage_en[s] = ~r_valid[s] | stage_en[s+1];
        end
    end

    assign take        = i_ifm_valid & i_wfm_valid & stage_en[0];
    assign o_ifm_ready = i_wfm_valid & stage_en[0];  // join, waits for peer
    assign o_wfm_ready = i_ifm_valid & stage_en[0];

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            r_valid <= '0;
        end else begin
            if (stage_en[0]) begin
                r_valid[0] <= take;
            end
            for (int s = 1; s < N_STAGES; s++) begin
                if (stage_en[s]) begin
                    r_valid[s] <= r_valid[s-1];  // bubbles move too
                end
            end
        end
    end

    assign o_ofm_valid = r_valid[N_STAGES-1];
    assign o_stage_en  = stage_en;

endmodule

`default_nettype wire

/* logic/mac_product_stage.sv */
////////////////////////////////////////////////////////////
// stage 0: element decode, lane multipliers, product regs
////////////////////////////////////////////////////////////
`default_nettype none

module mac_product_stage #(
    parameter int N_LANES = 8
) (
    input  logic                                  i_clk,
    input  logic                                  i_en,
    input  mac_pkg::mac_mode_e                    i_mode,
    input  mac_pkg::mac_elem_u [N_LANES-1:0]      i_ifm_data,
    input  mac_pkg::mac_elem_u [N_LANES-1:0]      i_wfm_data,
    input  logic [N_LANES-1:0]                    i_elem_valid,
    mac_prod_if.src                               prod
);
    import mac_pkg::*;

    logic [N_LANES-1:0]             p_zero;
    logic [N_LANES-1:0]             p_sign;
    logic [N_LANES-1:0][W_PEXP-1:0] p_exp;
    logic [N_LANES-1:0][W_PMAG-1:0] p_mag;
    logic [N_LANES-1:0]             p_keep;

    ////////////////////////////////////////////////////////////
    // decode and multiply
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            // zero flag and sign sit at the same bits in both formats
            p_zero[i] = i_ifm_data[i].fp8.is_zero | i_wfm_data[i].fp8.is_zero;
            p_sign[i] = i_ifm_data[i].fp8.sign ^ i_wfm_data[i].fp8.sign;
            if (i_mode == MODE_FP8) begin
                // exponents add, mantissas multiply
                p_exp[i]  = W_PEXP'(i_ifm_data[i].fp8.exp)
                          + W_PEXP'(i_wfm_data[i].fp8.exp);
                p_mag[i]  = W_PMAG'(i_ifm_data[i].fp8.mant)
                          * W_PMAG'(i_wfm_data[i].fp8.mant);
            end else begin
                p_exp[i]  = '0;                         // integers are unscaled
                p_mag[i]  = W_PMAG'(i_ifm_data[i].int9.mag)
                          * W_PMAG'(i_wfm_data[i].int9.mag);
            end
        end
    end

    assign p_keep = i_elem_valid & ~p_zero;

    ////////////////////////////////////////////////////////////
    // stage 0 registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            prod.sign <= p_sign;
            prod.exp  <= p_exp;
            prod.mag  <= p_mag;
            prod.keep <= p_keep;
            prod.mode <= i_mode;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_max_exp.sv */
////////////////////////////////////////////////////////////
// compare tree for the largest kept product exponent
////////////////////////////////////////////////////////////
`default_nettype none

module mac_max_exp #(
    parameter int N_LANES = 8
) (
    input  logic [N_LANES-1:0][mac_pkg::W_PEXP-1:0] i_exp,
    input  logic [N_LANES-1:0]                      i_keep,
    output logic [mac_pkg::W_PEXP-1:0]              o_max_exp
);
    import mac_pkg::*;

    // heap order, leaves in the upper half
    localparam int N_NODE = 2 * N_LANES - 1;

    logic [W_PEXP-1:0] node [N_NODE];

    always_comb begin
        // dropped lanes enter as 0, so an empty vector gives 0
        for (int i = 0; i < N_LANES; i++) begin
            node[N_LANES-1+i] = i_keep[i] ? i_exp[i] : '0;
        end
        for (int k = N_LANES - 2; k >= 0; k--) begin
            if (node[2*k+1] > node[2*k+2]) begin
                node[k] = node[2*k+1];
            end else begin
                node[k] = node[2*k+2];
            end
        end
    end

    assign o_max_exp = node[0];

endmodule

`default_nettype wire

/* logic/mac_align_stage.sv */
////////////////////////////////////////////////////////////
// stage 1: max exponent, differences, two's complement
// stage 2: clamped arithmetic right shift
////////////////////////////////////////////////////////////
`default_nettype none

module mac_align_stage #(
    parameter int N_LANES = 8
) (
    input  logic                                    i_clk,
    input  logic                                    i_en1,
    input  logic                                    i_en2,
    mac_prod_if.dst                                 prod,
    output logic [N_LANES-1:0][mac_pkg::W_PROD-1:0] o_aligned,
    output logic [mac_pkg::W_PEXP-1:0]              o_max_exp
);
    import mac_pkg::*;

    logic [W_PEXP-1:0]        max_exp;
    logic [W_PROD-1:0]        mag_ext [N_LANES];
    logic signed [W_PROD-1:0] tc      [N_LANES];
    logic [W_PEXP-1:0]        diff    [N_LANES];
    logic [W_PEXP-1:0]        shift   [N_LANES];

    logic signed [W_PROD-1:0] r1_prod  [N_LANES];
    logic [W_PEXP-1:0]        r1_shift [N_LANES];
    logic [W_PEXP-1:0]        r1_max_exp;

    mac_max_exp #(
        .N_LANES (N_LANES)
    ) u_max_exp (
        .i_exp     (prod.exp),
        .i_keep    (prod.keep),
        .o_max_exp (max_exp)
    );

    ////////////////////////////////////////////////////////////
    // stage 1
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            mag_ext[i] = {1'b0, prod.mag[i]};
            if (!prod.keep[i]) begin
                tc[i] = '0;                         // contributes nothing
            end else if (prod.sign[i]) begin
                tc[i] = ~mag_ext[i] + 1'b1;
            end else begin
                tc[i] = mag_ext[i];
            end

            diff[i] = max_exp - prod.exp[i];
            if (prod.mode == MODE_INT9) begin
                shift[i] = '0;                      // all on one scale
            end else if (diff[i] > W_PEXP'(SHIFT_CAP)) begin
                shift[i] = W_PEXP'(SHIFT_CAP);
            end else begin
                shift[i] = diff[i];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_en1) begin
            for (int i = 0; i < N_LANES; i++) begin
                r1_prod[i]  <= tc[i];
                r1_shift[i] <= shift[i];
            end
            r1_max_exp <= max_exp;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 2
    ////////////////////////////////////////////////////////////

    // floor rounding, small negatives end at -1
    always_ff @(posedge i_clk) begin
        if (i_en2) begin
            for (int i = 0; i < N_LANES; i++) begin
                o_aligned[i] <= r1_prod[i] >>> r1_shift[i];
            end
            o_max_exp <= r1_max_exp;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_sum_stage.sv */
////////////////////////////////////////////////////////////
// stage 3: signed adder tree and output registers
////////////////////////////////////////////////////////////
`default_nettype none

module mac_sum_stage #(
    parameter int N_LANES = 8
) (
    input  logic                                            i_clk,
    input  logic                                            i_en,
    input  logic [N_LANES-1:0][mac_pkg::W_PROD-1:0]         i_aligned,
    input  logic [mac_pkg::W_PEXP-1:0]                      i_max_exp,
    output logic signed [mac_pkg::W_PROD+$clog2(N_LANES)-1:0] o_sum,
    output logic [mac_pkg::W_PEXP-1:0]                      o_max_exp
);
    import mac_pkg::*;

    localparam int W_SUM  = W_PROD + $clog2(N_LANES);
    localparam int N_NODE = 2 * N_LANES - 1;

    logic signed [W_SUM-1:0] node [N_NODE];

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            node[N_LANES-1+i] = W_SUM'($signed(i_aligned[i]));  // sign extend
        end
        for (int k = N_LANES - 2; k >= 0; k--) begin
            node[k] = node[2*k+1] + node[2*k+2];
        end
    end

    // held while the ofm side stalls
    always_ff @(posedge i_clk) begin
        if (i_en) begin
            o_sum     <= node[0];
            o_max_exp <= i_max_exp;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_lane.sv */
////////////////////////////////////////////////////////////
// mac lane top: pipeline control and the four stages
////////////////////////////////////////////////////////////
`default_nettype none

module mac_lane #(
    parameter int N_LANES  = 8,
    parameter int N_STAGES = 4
) (
    input  logic                                              i_clk,
    input  logic                                              i_reset,
    input  mac_pkg::mac_mode_e                                i_mode,
    input  logic                                              i_ifm_valid,
    output logic                                              o_ifm_ready,
    input  mac_pkg::mac_elem_u [N_LANES-1:0]                  i_ifm_data,
    input  logic [N_LANES-1:0]                                i_ifm_elem_valid,
    input  logic                                              i_wfm_valid,
    output logic                                              o_wfm_ready,
    input  mac_pkg::mac_elem_u [N_LANES-1:0]                  i_wfm_data,
    input  logic                                              i_ofm_ready,
    output logic                                              o_ofm_valid,
    output logic signed [mac_pkg::W_PROD+$clog2(N_LANES)-1:0] o_ofm_sum,
    output logic [mac_pkg::W_PEXP-1:0]                        o_ofm_max_exp
);
    import mac_pkg::*;

    logic [N_STAGES-1:0]            stage_en;
    logic [N_LANES-1:0][W_PROD-1:0] aligned;
    logic [W_PEXP-1:0]              align_max_exp;

    mac_prod_if #(.N_LANES(N_LANES)) prod_if ();

    mac_pipe_ctrl #(
        .N_STAGES (N_STAGES)
    ) u_pipe_ctrl (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_ifm_valid (i_ifm_valid),
        .i_wfm_valid (i_wfm_valid),
        .o_ifm_ready (o_ifm_ready),
        .o_wfm_ready (o_wfm_ready),
        .i_ofm_ready (i_ofm_ready),
        .o_ofm_valid (o_ofm_valid),
        .o_stage_en  (stage_en)
    );

    mac_product_stage #(.N_LANES(N_LANES)) u_product (
        .i_clk        (i_clk),
        .i_en         (stage_en[0]),
        .i_mode       (i_mode),
        .i_ifm_data   (i_ifm_data),
        .i_wfm_data   (i_wfm_data),
        .i_elem_valid (i_ifm_elem_valid),
        .prod         (prod_if)
    );

    mac_align_stage #(.N_LANES(N_LANES)) u_align (
        .i_clk     (i_clk),
        .i_en1     (stage_en[1]),
        .i_en2     (stage_en[2]),
        .prod      (prod_if),
        .o_aligned (aligned),
        .o_max_exp (align_max_exp)
    );

    mac_sum_stage #(.N_LANES(N_LANES)) u_sum (
        .i_clk     (i_clk),
        .i_en      (stage_en[3]),
        .i_aligned (aligned),
        .i_max_exp (align_max_exp),
        .o_sum     (o_ofm_sum),
        .o_max_exp (o_ofm_max_exp)
    );

endmodule

`default_nettype wire

/* bench/mac_lane_tb.sv */
////////////////////////////////////////////////////////////
// mac lane testbench: vectors from the data file, random
// ifm/wfm join timing and ofm back-pressure, in-order check
////////////////////////////////////////////////////////////
`default_nettype none

module mac_lane_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mac_pkg::*;

    localparam int N_LANES  = 8;
    localparam int N_STAGES = 4;
    localparam int N_VEC    = 18;
    localparam int N_FIELD  = 20;   // words per vector line
    localparam int N_ROUNDS = 3;
    localparam int TIMEOUT  = 200;  // cycles

    logic                                     i_clk = 1'b0;
    logic                                     i_reset;
    mac_mode_e                                i_mode;
    logic                                     i_ifm_valid, i_wfm_valid, i_ofm_ready;
    logic                                     o_ifm_ready, o_wfm_ready, o_ofm_valid;
    mac_elem_u [N_LANES-1:0]                  i_ifm_data, i_wfm_data;
    logic [N_LANES-1:0]                       i_ifm_elem_valid;
    logic signed [W_PROD+$clog2(N_LANES)-1:0] o_ofm_sum;
    logic [W_PEXP-1:0]                        o_ofm_max_exp;

    logic [31:0] tdata [N_VEC*N_FIELD];
    logic [31:0] lfsr;
    logic [31:0] exp_sum_q [$];
    logic [31:0] exp_max_q [$];
    int          n_checked;

    mac_lane #(.N_LANES(N_LANES), .N_STAGES(N_STAGES)) u_dut (
        .i_clk (i_clk), .i_reset (i_reset), .i_mode (i_mode),
        .i_ifm_valid (i_ifm_valid), .o_ifm_ready (o_ifm_ready),
        .i_ifm_data (i_ifm_data), .i_ifm_elem_valid (i_ifm_elem_valid),
        .i_wfm_valid (i_wfm_valid), .o_wfm_ready (o_wfm_ready), .i_wfm_data (i_wfm_data),
        .i_ofm_ready (i_ofm_ready), .o_ofm_valid (o_ofm_valid),
        .o_ofm_sum (o_ofm_sum), .o_ofm_max_exp (o_ofm_max_exp)
    );

    always #2 i_clk = ~i_clk;

    // galois lfsr, one step per bit
    function automatic int lfsr_bits(input int n);
        int r;
        r = 0;
        for (int k = 0; k < n; k++) begin
            r    = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            stop_run($sformatf("mismatch at %0t: %s, got %h, expected %h",
                               $time, what, got, want));
        end
    endtask

    task automatic send_vector(input int v);
        int   base;
        int   d_ifm;
        int   d_wfm;
        int   cyc;
        logic fired;
        base             = v * N_FIELD;
        i_mode           = mac_mode_e'(tdata[base][0]);
        i_ifm_elem_valid = tdata[base+1][N_LANES-1:0];
        for (int i = 0; i < N_LANES; i++) begin
            i_ifm_data[i] = tdata[base+2+i][W_ELEM-1:0];
            i_wfm_data[i] = tdata[base+2+N_LANES+i][W_ELEM-1:0];
        end
        d_ifm = lfsr_bits(1) ? lfsr_bits(2) : 0;   // one channel often lags
        d_wfm = lfsr_bits(1) ? lfsr_bits(2) : 0;
        cyc   = 0;
        fired = 1'b0;
        while (!fired) begin
            i_ifm_valid = (cyc >= d_ifm);
            i_wfm_valid = (cyc >= d_wfm);
            @(negedge i_clk);
            fired = i_ifm_valid & i_wfm_valid & o_ifm_ready & o_wfm_ready;
            @(posedge i_clk);
            #1;
            cyc++;
            if (!fired && cyc > TIMEOUT) stop_run("timeout: vector was never accepted");
        end
        i_ifm_valid = 1'b0;
        i_wfm_valid = 1'b0;
        exp_sum_q.push_back(tdata[base+18]);
        exp_max_q.push_back(tdata[base+19]);
    endtask

    task automatic receive_all(input int total);
        int          idle;
        logic        pending;
        logic        full;
        logic        next_ready;
        logic [31:0] held_sum;
        logic [31:0] held_exp;
        idle    = 0;
        pending = 1'b0;
        while (n_checked < total) begin
            @(negedge i_clk);
            if (pending) begin     // stalled result
                check_value(32'(o_ofm_valid), 1, "ofm valid dropped before ready");
                check_value(32'($unsigned(o_ofm_sum)), held_sum, "stalled ofm sum changed");
                check_value(32'(o_ofm_max_exp), held_exp, "stalled ofm exponent changed");
            end
            // every stage holds a vector and nothing leaves
            full = (exp_sum_q.size() == N_STAGES) && !i_ofm_ready;
            check_value(32'(o_ifm_ready), 32'(i_wfm_valid & ~full), "ifm ready");
            check_value(32'(o_wfm_ready), 32'(i_ifm_valid & ~full), "wfm ready");
            pending  = o_ofm_valid & ~i_ofm_ready;
            held_sum = 32'($unsigned(o_ofm_sum));
            held_exp = 32'(o_ofm_max_exp);
            if (o_ofm_valid && i_ofm_ready) begin
                if (exp_sum_q.size() == 0) stop_run("result seen with no vector outstanding");
                check_value(held_sum, exp_sum_q.pop_front(), "ofm sum");
                check_value(held_exp, exp_max_q.pop_front(), "ofm max exponent");
                n_checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) stop_run("timeout: no result accepted for too long");
            end
            next_ready = lfsr_bits(1);
            @(posedge i_clk);
            #1;
            i_ofm_ready = next_ready;
        end
    endtask

    initial begin
        i_reset          = 1'b0;
        i_mode           = MODE_FP8;
        i_ifm_valid      = 1'b0;
        i_wfm_valid      = 1'b0;
        i_ofm_ready      = 1'b0;
        i_ifm_data       = '0;
        i_wfm_data       = '0;
        i_ifm_elem_valid = '0;
        lfsr             = 32'hba58;
        n_checked        = 0;
        for (int i = 0; i < N_VEC * N_FIELD; i++) begin
            tdata[i] = ~32'(i);     // words the file never wrote
        end
        $readmemh("bench/mac_lane_testdata.txt", tdata);
        if (tdata[N_VEC*N_FIELD-1] == ~32'(N_VEC * N_FIELD - 1)) begin
            stop_run("test data file missing or short");
        end
        repeat (16) @(posedge i_clk);
        #1;
        i_reset = 1'b1;
        fork
            for (int r = 0; r < N_ROUNDS * N_VEC; r++) send_vector(r % N_VEC);
            receive_all(N_ROUNDS * N_VEC);
        join
        if (n_checked == N_ROUNDS * N_VEC && exp_sum_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_run("result count does not match the vectors sent");
        end
    end

endmodule

`default_nettype wire

/* mac_lane.f */
logic/mac_pkg.sv
logic/mac_pipe_ctrl.sv
logic/mac_product_stage.sv
logic/mac_max_exp.sv
logic/mac_align_stage.sv
logic/mac_sum_stage.sv
logic/mac_lane.sv
bench/mac_lane_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the mac lane testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f mac_lane.f --top-module mac_lane_tb -o mac_lane_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/mac_lane_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* bench/mac_lane_testdata.txt */
// mode(0 fp8, 1 int9) mask ifm lane0..7 wfm lane0..7 sum(20b) max_exp
// element: bit9 zero flag, bit8 sign, fp8 exp[7:4] mant[3:0], int9 mag[7:0]
0 ff 001 002 003 004 005 006 007 008 001 001 001 001 001 001 001 001 00024 00
0 ff 023 114 021 10f 011 012 003 117 015 002 021 00f 101 012 003 113 ffffd 04
0 ff 0ff 105 00f 1ff 181 0d2 1d2 0f8 0ff 003 00f 0ff 001 004 004 0e2 00005 1e
0 5a 0ff 032 0e1 124 013 0f1 2f3 0ff 0ff 013 0e1 023 003 0f1 0f3 0ff ffffb 04
0 00 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 1ff 1ff 1ff 1ff 1ff 1ff 1ff 1ff 00000 00
0 ff 077 077 077 077 077 077 077 077 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 00000 00
1 ff 0ff 1ff 064 10a 007 080 101 000 0ff 0ff 032 114 108 080 001 0ff 05417 00
1 ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 7f008 00
1 ff 1ff 1ff 1ff 1ff 1ff 1ff 1ff 1ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 80ff8 00
1 0f 010 205 103 020 0ff 0ff 0ff 0ff 010 005 011 121 0ff 0ff 0ff 0ff ffcad 00
0 ff 058 05f 047 147 011 111 080 07c 032 13f 016 016 011 011 001 10a ffef1 08
1 a5 1c8 0ff 0c8 0ff 0ff 033 0ff 111 0c8 0ff 0c8 0ff 0ff 003 0ff 102 000bb 00
0 ff 1f1 1f1 1f1 1f1 1f1 1f1 1f1 1f1 0f1 0f1 0f1 0f1 0f1 0f1 0f1 0f1 ffff8 1e
0 81 0a9 0ff 0ff 0ff 0ff 0ff 0ff 135 033 0ff 0ff 0ff 0ff 0ff 0ff 0b7 fffea 0e
1 ff 023 114 021 10f 011 012 003 117 015 002 021 00f 101 012 003 113 00908 00
0 ff 0ff 1ff 064 10a 007 080 101 000 0ff 0ff 032 114 108 080 001 0ff ffffe 1e
0 ff 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 00000 00
1 ff 2ff 2ff 2ff 2ff 2ff 2ff 2ff 2ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 0ff 00000 00
